//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_cpu_core
FILELIST  ?= cpu_core.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Result: FAILED" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- alu.sv
`include "core_macros.svh"

module alu
    import core_pkg::*;
(
    input  alu_op_t             op,
    input  logic [`DATA_W-1:0]  a,
    input  logic [`DATA_W-1:0]  b,
    input  logic                carry_in,
    output logic [`DATA_W-1:0]  result,
    output flags_t              flags_out
);

    logic              subtract;
    logic              cin;
    logic [`DATA_W:0]  full;
    logic [4:0]        nibble;    // Bit 4 is the half carry or borrow

    always_comb
    begin
        subtract = (op == ALU_SUB) || (op == ALU_SBC) || (op == ALU_CP);
        cin = ((op == ALU_ADC) || (op == ALU_SBC)) ? carry_in : 1'b0;
        if (subtract)
        begin
            full   = {1'b0, a} - {1'b0, b} - {{`DATA_W{1'b0}}, cin};
            nibble = {1'b0, a[3:0]} - {1'b0, b[3:0]} - {4'b0000, cin};
        end
        else
        begin
            full   = {1'b0, a} + {1'b0, b} + {{`DATA_W{1'b0}}, cin};
            nibble = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'b0000, cin};
        end
    end

    always_comb
    begin
        result      = full[`DATA_W-1:0];
        flags_out.n = subtract;
        flags_out.h = nibble[4];
        flags_out.c = full[`DATA_W];
        case (op)
            ALU_AND:
            begin
                result      = a & b;
                flags_out.h = 1'b1;
                flags_out.c = 1'b0;
            end
            ALU_XOR:
            begin
                result      = a ^ b;
                flags_out.h = 1'b0;
                flags_out.c = 1'b0;
            end
            ALU_OR:
            begin
                result      = a | b;
                flags_out.h = 1'b0;
                flags_out.c = 1'b0;
            end
            ALU_CP:  result = a;    // Flags still from a - b
            default: result = full[`DATA_W-1:0];
        endcase
        flags_out.z = (op == ALU_CP) ? (full[`DATA_W-1:0] == '0) : (result == '0);
    end

endmodule

//--- bus_unit.sv
`include "core_macros.svh"

module bus_unit
    import core_pkg::*;
(
    input  logic                clock,
    input  logic                rst,
    input  logic                start,
    input  logic                write,
    input  bus_src_t            addr_src,
    input  logic [`ADDR_W-1:0]  pc,
    input  logic [`ADDR_W-1:0]  hl,
    input  logic [`ADDR_W-1:0]  operand_addr,
    input  logic [`DATA_W-1:0]  wdata,
    input  logic                mem_ack,
    input  logic [`DATA_W-1:0]  mem_rdata,
    output logic                mem_req,
    output logic                mem_we,
    output logic [`ADDR_W-1:0]  mem_addr,
    output logic [`DATA_W-1:0]  mem_wdata,
    output logic                done,
    output logic [`DATA_W-1:0]  rdata
);

    typedef enum logic [1:0]
    {
        BUS_IDLE,
        BUS_REQ,
        BUS_RELEASE
    } bus_state_t;

    bus_state_t         state;
    logic [`ADDR_W-1:0] addr_sel;

    always_comb
    begin
        case (addr_src)
            SRC_HL:      addr_sel = hl;
            SRC_OPERAND: addr_sel = operand_addr;
            default:     addr_sel = pc;
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            state   <= BUS_IDLE;
            mem_req <= 1'b0;
            mem_we  <= 1'b0;
            done    <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                BUS_IDLE:
                    if (start)
                    begin
                        mem_req <= 1'b1;
                        mem_we  <= write;
                        state   <= BUS_REQ;
                    end
                BUS_REQ:
                    if (mem_ack)
                    begin
                        mem_req <= 1'b0;
                        state   <= BUS_RELEASE;
                    end
                BUS_RELEASE:
                    if (!mem_ack)   // Wait for ack to drop before next request
                    begin
                        mem_we <= 1'b0;
                        done   <= 1'b1;
                        state  <= BUS_IDLE;
                    end
                default: state <= BUS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock)
    begin
        if ((state == BUS_IDLE) && start)
        begin
            mem_addr  <= addr_sel;
            mem_wdata <= wdata;
        end
        if ((state == BUS_REQ) && mem_ack && !mem_we)
            rdata <= mem_rdata;     // Valid while ack high
    end

endmodule

//--- control_unit.sv
`include "core_macros.svh"

module control_unit
    import core_pkg::*;
(
    input  logic                clock,
    input  logic                rst,
    input  logic                done,
    input  logic [`DATA_W-1:0]  rdata,
    input  logic [`DATA_W-1:0]  read_b,
    input  logic [`DATA_W-1:0]  alu_result,
    input  logic                taken,
    input  flags_t              flags,
    output logic                start,
    output logic                write,
    output bus_src_t            addr_src,
    output logic [`ADDR_W-1:0]  operand_addr,
    output logic [`DATA_W-1:0]  wdata,
    output logic [`ADDR_W-1:0]  pc,
    output reg_idx_t            read_a_idx,
    output reg_idx_t            read_b_idx,
    output reg_idx_t            write_idx,
    output logic                write_en,
    output logic [`DATA_W-1:0]  write_data,
    output alu_op_t             alu_op,
    output logic [`DATA_W-1:0]  alu_b,
    output logic                carry_in,
    output logic                flag_write,
    output cond_t               cond,
    output logic                halted
);

    cu_state_t          state;
    logic [`DATA_W-1:0] ir;
    logic [`DATA_W-1:0] op_lo;
    logic [`DATA_W-1:0] op_hi;
    logic               issued;     // Bus access of this state already started
    logic               jump_pend;  // Next fetch comes from the jump target
    logic [`ADDR_W-1:0] fetch_addr;
    logic               need_bus;

    logic [1:0]         grp;
    reg_idx_t           dst;
    reg_idx_t           src;
    logic               src_mem;
    logic               dst_mem;
    logic               is_halt;
    logic               is_ld_rr;
    logic               is_ld_rn;
    logic               is_alu_r;
    logic               is_alu_n;
    logic               is_alu;
    logic               is_jp;
    logic               is_jp_cc;
    logic               is_jump;

    // Decode
    assign grp      = ir[`OP_GRP_HI:`OP_GRP_LO];
    assign dst      = reg_idx_t'(ir[`OP_DST_HI:`OP_DST_LO]);
    assign src      = reg_idx_t'(ir[`OP_SRC_HI:`OP_SRC_LO]);
    assign src_mem  = (src == `REG_HL_MEM);
    assign dst_mem  = (dst == `REG_HL_MEM);
    assign is_halt  = (ir == 8'h76);
    assign is_ld_rr = (grp == 2'b01) && !is_halt;
    assign is_ld_rn = (grp == 2'b00) && src_mem;
    assign is_alu_r = (grp == 2'b10);
    assign is_alu_n = (grp == 2'b11) && src_mem;
    assign is_alu   = is_alu_r || is_alu_n;
    assign is_jp    = (ir == 8'hc3);
    assign is_jp_cc = (ir[7:5] == 3'b110) && (src == 3'b010);
    assign is_jump  = is_jp || is_jp_cc;

    // Bus requests
    assign need_bus = (state == ST_FETCH) || (state == ST_OPER_LO) || (state == ST_OPER_HI)
                      || (state == ST_MEM_RD) || (state == ST_MEM_WR);
    assign start        = need_bus && !issued;
    assign write        = (state == ST_MEM_WR);
    assign operand_addr = {op_hi, op_lo};
    assign fetch_addr   = jump_pend ? operand_addr : pc;
    assign wdata        = is_ld_rn ? rdata : read_b;   // LD (HL),n reuses the latched operand

    always_comb
    begin
        if (state == ST_FETCH)
            addr_src = jump_pend ? SRC_OPERAND : SRC_PC;
        else if ((state == ST_MEM_RD) || (state == ST_MEM_WR))
            addr_src = SRC_HL;
        else
            addr_src = SRC_PC;
    end

    // Register file, ALU and flags
    assign read_a_idx = reg_idx_t'(`REG_A);
    assign read_b_idx = src;
    assign write_idx  = is_alu ? reg_idx_t'(`REG_A) : dst;
    assign write_en   = (state == ST_EXEC) && (is_alu || ((is_ld_rr || is_ld_rn) && !dst_mem));
    assign alu_op     = alu_op_t'(ir[`OP_DST_HI:`OP_DST_LO]);
    assign alu_b      = (is_alu_n || src_mem) ? rdata : read_b;
    assign carry_in   = flags.c;
    assign flag_write = (state == ST_EXEC) && is_alu;
    assign cond       = cond_t'(ir[`OP_CC_HI:`OP_CC_LO]);
    assign halted     = (state == ST_HALT);

    always_comb
    begin
        if (is_alu)
            write_data = alu_result;
        else if (is_ld_rr && !src_mem)
            write_data = read_b;
        else
            write_data = rdata;     // Immediate or (HL) byte
    end

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            state     <= ST_FETCH;
            pc        <= `RESET_PC;
            issued    <= 1'b0;
            jump_pend <= 1'b0;
        end
        else
        begin
            if (done)
                issued <= 1'b0;
            else if (start)
                issued <= 1'b1;
            case (state)
                ST_FETCH:
                    if (done)
                    begin
                        pc        <= fetch_addr + `ADDR_W'(1);
                        jump_pend <= 1'b0;
                        state     <= ST_DECODE;
                    end
                ST_DECODE:
                    if (is_halt)
                        state <= ST_HALT;
                    else if ((is_ld_rr || is_alu_r) && src_mem)
                        state <= ST_MEM_RD;
                    else if (is_ld_rr && dst_mem)
                        state <= ST_MEM_WR;
                    else if (is_ld_rn || is_alu_n || is_jump)
                        state <= ST_OPER_LO;
                    else
                        state <= ST_EXEC;   // Also NOP and unknown opcodes
                ST_OPER_LO:
                    if (done)
                    begin
                        pc <= pc + `ADDR_W'(1);
                        if (is_jump)
                            state <= ST_OPER_HI;
                        else if (is_ld_rn && dst_mem)
                            state <= ST_MEM_WR;
                        else
                            state <= ST_EXEC;
                    end
                ST_OPER_HI:
                    if (done)
                    begin
                        pc    <= pc + `ADDR_W'(1);
                        state <= ST_EXEC;
                    end
                ST_MEM_RD:
                    if (done)
                        state <= ST_EXEC;
                ST_MEM_WR:
                    if (done)
                        state <= ST_FETCH;
                ST_EXEC:
                begin
                    jump_pend <= is_jump && (is_jp || taken);
                    state     <= ST_FETCH;
                end
                default: state <= ST_HALT;  // Held until reset
            endcase
        end
    end

    // Instruction and operand buffers
    always_ff @(posedge clock)
    begin
        if ((state == ST_FETCH) && done)
            ir <= rdata;
        if ((state == ST_OPER_LO) && done)
            op_lo <= rdata;
        if ((state == ST_OPER_HI) && done)
            op_hi <= rdata;
    end

endmodule

//--- core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

`define DATA_W      8
`define ADDR_W      16
`define RESET_PC    16'h0000
`define NUM_REGS    8

`define REG_HL_MEM  3'b110      // (HL), goes to memory
`define REG_A       3'b111

// Opcode fields
`define OP_GRP_HI   7
`define OP_GRP_LO   6
`define OP_DST_HI   5
`define OP_DST_LO   3
`define OP_SRC_HI   2
`define OP_SRC_LO   0
`define OP_CC_HI    4
`define OP_CC_LO    3

`endif

//--- core_pkg.sv
package core_pkg;

    // Same order as opcode bits 5:3
    typedef enum logic [2:0]
    {
        ALU_ADD,
        ALU_ADC,
        ALU_SUB,
        ALU_SBC,
        ALU_AND,
        ALU_XOR,
        ALU_OR,
        ALU_CP
    } alu_op_t;

    typedef enum logic [2:0]
    {
        R_B,
        R_C,
        R_D,
        R_E,
        R_H,
        R_L,
        R_HL,
        R_A
    } reg_idx_t;

    typedef struct packed
    {
        logic z;
        logic n;
        logic h;
        logic c;
    } flags_t;

    typedef enum logic [1:0]
    {
        COND_NZ,
        COND_Z,
        COND_NC,
        COND_C
    } cond_t;

    typedef enum logic [2:0]
    {
        ST_FETCH,
        ST_DECODE,
        ST_OPER_LO,
        ST_OPER_HI,
        ST_MEM_RD,
        ST_MEM_WR,
        ST_EXEC,
        ST_HALT
    } cu_state_t;

    typedef enum logic [1:0]
    {
        SRC_PC,
        SRC_HL,
        SRC_OPERAND
    } bus_src_t;

endpackage

//--- cpu_core.f
+incdir+.
core_pkg.sv
alu.sv
flag_reg.sv
reg_file.sv
bus_unit.sv
control_unit.sv
cpu_core.sv
cpu_core_props.sv
tb_checker.sv
tb_cpu_core.sv

//--- cpu_core.sv
`include "core_macros.svh"

module cpu_core
    import core_pkg::*;
(
    input  logic                clock,
    input  logic                rst,
    output logic                mem_req,
    output logic                mem_we,
    output logic [`ADDR_W-1:0]  mem_addr,
    output logic [`DATA_W-1:0]  mem_wdata,
    input  logic                mem_ack,
    input  logic [`DATA_W-1:0]  mem_rdata,
    output logic                halted
);

    logic               bus_start;
    logic               bus_write;
    bus_src_t           addr_src;
    logic [`ADDR_W-1:0] operand_addr;
    logic [`DATA_W-1:0] bus_wdata;
    logic [`ADDR_W-1:0] pc;
    logic               bus_done;
    logic [`DATA_W-1:0] bus_rdata;

    reg_idx_t           read_a_idx;
    reg_idx_t           read_b_idx;
    reg_idx_t           write_idx;
    logic               reg_write_en;
    logic [`DATA_W-1:0] reg_write_data;
    logic [`DATA_W-1:0] read_a;
    logic [`DATA_W-1:0] read_b;
    logic [`ADDR_W-1:0] hl;

    alu_op_t            alu_op;
    logic [`DATA_W-1:0] alu_b;
    logic               carry_in;
    logic [`DATA_W-1:0] alu_result;
    flags_t             alu_flags;
    flags_t             flags;
    logic               flag_write;
    cond_t              cond;
    logic               taken;

    control_unit control_unit_inst (
        .clock        (clock),
        .rst          (rst),
        .done         (bus_done),
        .rdata        (bus_rdata),
        .read_b       (read_b),
        .alu_result   (alu_result),
        .taken        (taken),
        .flags        (flags),
        .start        (bus_start),
        .write        (bus_write),
        .addr_src     (addr_src),
        .operand_addr (operand_addr),
        .wdata        (bus_wdata),
        .pc           (pc),
        .read_a_idx   (read_a_idx),
        .read_b_idx   (read_b_idx),
        .write_idx    (write_idx),
        .write_en     (reg_write_en),
        .write_data   (reg_write_data),
        .alu_op       (alu_op),
        .alu_b        (alu_b),
        .carry_in     (carry_in),
        .flag_write   (flag_write),
        .cond         (cond),
        .halted       (halted)
    );

    bus_unit bus_unit_inst (
        .clock        (clock),
        .rst          (rst),
        .start        (bus_start),
        .write        (bus_write),
        .addr_src     (addr_src),
        .pc           (pc),
        .hl           (hl),
        .operand_addr (operand_addr),
        .wdata        (bus_wdata),
        .mem_ack      (mem_ack),
        .mem_rdata    (mem_rdata),
        .mem_req      (mem_req),
        .mem_we       (mem_we),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .done         (bus_done),
        .rdata        (bus_rdata)
    );

    reg_file reg_file_inst (
        .clock      (clock),
        .read_a_idx (read_a_idx),
        .read_b_idx (read_b_idx),
        .write_idx  (write_idx),
        .write_en   (reg_write_en),
        .write_data (reg_write_data),
        .read_a     (read_a),
        .read_b     (read_b),
        .hl         (hl)
    );

    alu alu_inst (
        .op        (alu_op),
        .a         (read_a),    // Always A
        .b         (alu_b),
        .carry_in  (carry_in),
        .result    (alu_result),
        .flags_out (alu_flags)
    );

    flag_reg flag_reg_inst (
        .clock    (clock),
        .rst      (rst),
        .write    (flag_write),
        .flags_in (alu_flags),
        .cond     (cond),
        .flags    (flags),
        .taken    (taken)
    );

endmodule

//--- cpu_core_props.sv
module cpu_core_props (
    input logic        clock,
    input logic        rst,
    input logic        mem_req,
    input logic        mem_ack,
    input logic        mem_we,
    input logic [15:0] mem_addr,
    input logic        halted
);

    timeunit 1ns;
    timeprecision 1ps;

    // Request held until memory answers
    req_hold: assert property (@(posedge clock) disable iff (rst)
        (mem_req && !mem_ack) |=> mem_req)
        else $error("mem_req fell before mem_ack");

    addr_stable: assert property (@(posedge clock) disable iff (rst)
        (mem_req && !mem_ack) |=> ($stable(mem_addr) && $stable(mem_we)))
        else $error("mem_addr or mem_we changed during a request");

    reset_idle: assert property (@(posedge clock)
        rst |=> (!mem_req && !halted))
        else $error("mem_req or halted high after reset");

endmodule

bind cpu_core cpu_core_props cpu_core_props_inst (
    .clock    (clock),
    .rst      (rst),
    .mem_req  (mem_req),
    .mem_ack  (mem_ack),
    .mem_we   (mem_we),
    .mem_addr (mem_addr),
    .halted   (halted)
);

//--- flag_reg.sv
module flag_reg
    import core_pkg::*;
(
    input  logic    clock,
    input  logic    rst,
    input  logic    write,
    input  flags_t  flags_in,
    input  cond_t   cond,
    output flags_t  flags,
    output logic    taken
);

    always_ff @(posedge clock)
    begin
        if (rst)
            flags <= '0;
        else if (write)
            flags <= flags_in;      // All four at once
    end

    // Branch condition from opcode bits 4:3
    always_comb
    begin
        case (cond)
            COND_NZ: taken = !flags.z;
            COND_Z:  taken = flags.z;
            COND_NC: taken = !flags.c;
            COND_C:  taken = flags.c;
            default: taken = 1'b0;
        endcase
    end

endmodule

//--- reg_file.sv
`include "core_macros.svh"

module reg_file (
    input  logic                clock,
    input  logic [2:0]          read_a_idx,
    input  logic [2:0]          read_b_idx,
    input  logic [2:0]          write_idx,
    input  logic                write_en,
    input  logic [`DATA_W-1:0]  write_data,
    output logic [`DATA_W-1:0]  read_a,
    output logic [`DATA_W-1:0]  read_b,
    output logic [`ADDR_W-1:0]  hl
);

    logic [`DATA_W-1:0] regs [`NUM_REGS];

    always_ff @(posedge clock)
    begin
        if (write_en && (write_idx != `REG_HL_MEM))
            regs[write_idx] <= write_data;
    end

    assign read_a = regs[read_a_idx];
    assign read_b = regs[read_b_idx];
    assign hl     = {regs[3'd4], regs[3'd5]};  // H then L

endmodule

//--- tb_checker.sv
module tb_checker (
    input  logic         clock,
    input  logic         rst,
    input  logic         mem_req,
    input  logic         mem_ack,
    input  logic         mem_we,
    input  logic [15:0]  mem_addr,
    input  logic [7:0]   mem_wdata,
    input  logic         halted,
    input  logic         begin_test,
    input  logic         end_test,
    input  int           test_id,
    input  int           exp_count,
    input  logic [119:0] exp_vec,
    output int           pass_count,
    output int           fail_count
);

    timeunit 1ns;
    timeprecision 1ps;

    int          seen = 0;
    logic        bad = 1'b0;
    logic        halt_flagged = 1'b0;
    logic        halt_seen = 1'b0;     // Sticky until the next test
    logic [23:0] entry;

    initial
    begin
        pass_count = 0;
        fail_count = 0;
    end

    always @(posedge clock)
    begin
        if (begin_test)
        begin
            seen = 0;
            bad = 1'b0;
            halt_flagged = 1'b0;
            halt_seen = 1'b0;
        end
        else
        begin
            if (mem_req && mem_ack && mem_we)   // One overlap cycle per write
            begin
                if (seen < exp_count)
                begin
                    entry = exp_vec[24*(exp_count-1-seen) +: 24];
                    if (mem_addr != entry[23:8])
                    begin
                        $display("[ERROR] time=%0t mem_addr expected 0x%04h got 0x%04h",
                                 $time, entry[23:8], mem_addr);
                        bad = 1'b1;
                    end
                    if (mem_wdata != entry[7:0])
                    begin
                        $display("[ERROR] time=%0t mem_wdata expected 0x%02h got 0x%02h",
                                 $time, entry[7:0], mem_wdata);
                        bad = 1'b1;
                    end
                end
                else
                begin
                    $display("Test %0d has an extra write of 0x%02h to 0x%04h",
                             test_id, mem_wdata, mem_addr);
                    bad = 1'b1;
                end
                seen = seen + 1;
            end
            if (halt_seen && !halted && !rst && !halt_flagged)
            begin
                $display("Test %0d: halted fell before the next reset", test_id);
                halt_flagged = 1'b1;
                bad = 1'b1;
            end
            if ((halted || halt_seen) && mem_req && !rst && !halt_flagged)
            begin
                $display("Test %0d: the core started a memory access after HALT", test_id);
                halt_flagged = 1'b1;
                bad = 1'b1;
            end
            if (halted)
                halt_seen = 1'b1;
            if (end_test)
            begin
                if (seen < exp_count)
                begin
                    $display("Test %0d is missing %0d of %0d writes",
                             test_id, exp_count - seen, exp_count);
                    bad = 1'b1;
                end
                $display("Test %0d %s (%0d writes seen)", test_id, bad ? "failed" : "passed",
                         seen);
                if (bad)
                    fail_count = fail_count + 1;
                else
                    pass_count = pass_count + 1;
            end
        end
    end

endmodule

//--- tb_cpu_core.sv
`include "core_macros.svh"

module tb_cpu_core;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_TESTS = 6;
    localparam int MAX_EXP   = 5;

    logic                clock = 1'b0;
    logic                rst = 1'b1;
    logic                mem_req;
    logic                mem_we;
    logic [`ADDR_W-1:0]  mem_addr;
    logic [`DATA_W-1:0]  mem_wdata;
    logic                mem_ack = 1'b0;
    logic [`DATA_W-1:0]  mem_rdata = '0;
    logic                halted;

    logic                begin_test = 1'b0;
    logic                end_test = 1'b0;
    int                  test_id = 0;
    int                  exp_count = 0;
    logic [24*MAX_EXP-1:0] exp_vec = '0;
    int                  pass_count;
    int                  fail_count;

    // Program bytes right-aligned, first byte highest
    logic [511:0]          prog_tbl [NUM_TESTS];
    int                    prog_len [NUM_TESTS];
    logic [24*MAX_EXP-1:0] exp_tbl [NUM_TESTS];     // {addr, data} per write
    int                    exp_n [NUM_TESTS];

    logic [7:0]  mem [256];
    logic [7:0]  image [256];
    logic [31:0] lfsr = 32'h95ef8b53;
    int          wait_cnt = 0;
    logic        pending = 1'b0;
    int          cycles = 0;
    int          cycle_limit = 0;

    cpu_core cpu_core_inst (
        .clock     (clock),
        .rst       (rst),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata),
        .halted    (halted)
    );

    tb_checker tb_checker_inst (
        .clock      (clock),
        .rst        (rst),
        .mem_req    (mem_req),
        .mem_ack    (mem_ack),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .halted     (halted),
        .begin_test (begin_test),
        .end_test   (end_test),
        .test_id    (test_id),
        .exp_count  (exp_count),
        .exp_vec    (exp_vec),
        .pass_count (pass_count),
        .fail_count (fail_count)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    task automatic set_row(input int idx, input int len, input logic [511:0] prog,
                           input int n, input logic [24*MAX_EXP-1:0] exp);
        prog_tbl[idx] = prog;
        prog_len[idx] = len;
        exp_n[idx]    = n;
        exp_tbl[idx]  = exp;
    endtask

    initial
    begin
        forever
            #4 clock = ~clock;
    end

    // Memory model, answers after 0 to 3 cycles
    always @(negedge clock)
    begin
        logic [1:0] delay;
        if (rst)
        begin
            mem_ack <= 1'b0;
            pending = 1'b0;
            for (int i = 0; i < 256; i++)
                mem[i] = image[i];
        end
        else if (mem_ack)
        begin
            if (!mem_req)
                mem_ack <= 1'b0;
        end
        else if (mem_req)
        begin
            if (!pending)
            begin
                delay[0] = lfsr[0];
                lfsr = lfsr_next(lfsr);
                delay[1] = lfsr[0];
                lfsr = lfsr_next(lfsr);
                wait_cnt = int'(delay);
                pending = 1'b1;
            end
            if (wait_cnt == 0)
            begin
                mem_ack   <= 1'b1;
                mem_rdata <= mem[mem_addr[7:0]];
                if (mem_we)
                    mem[mem_addr[7:0]] = mem_wdata;
                pending = 1'b0;
            end
            else
                wait_cnt = wait_cnt - 1;
        end
    end

    always @(posedge clock)
    begin
        cycles <= cycles + 1;
        if ((cycle_limit > 0) && (cycles >= cycle_limit))
        begin
            $display("Timeout after %0d cycles, the core did not reach HALT", cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial
    begin
        set_row(0, 18, 512'h06110E2251_26002E8070_2E8172_2E8236A5_76,
                3, 120'h008011_008122_0082A5);
        set_row(1, 30, 512'h26002E903E3C060F8077_2E91D60B77_2E92A077_2E93F65A77_2E94EEFF77_76,
                5, 120'h00904B_009140_009200_00935A_0094A5);
        set_row(2, 29, 512'h26002EA03EF0C620CE0577_2EA1CE0177_2EA2D620DE0177_2EA3FEF577_76,
                4, 120'h00A016_00A117_00A2F5_00A3F5);
        set_row(3, 19, 512'h26002E10462E117E802E12862EB07776_123405,
                1, 120'h00B04B);
        set_row(4, 41, 512'h26002EC0C30A003E9977_3E01FE01CA1400770000_D21900770077FE02CA22_002EC177D228002EC277_76,
                3, 120'h00C001_00C101_00C201);
        set_row(5, 8, 512'h3E7726002ED07776,
                1, 120'h00D077);

        // Four accesses of eight cycles per byte and write
        for (int t = 0; t < NUM_TESTS; t++)
            cycle_limit += (prog_len[t] + exp_n[t]) * 4 * 8;

        for (int t = 0; t < NUM_TESTS; t++)
        begin
            for (int i = 0; i < 256; i++)
            begin
                if (i < prog_len[t])
                    image[i] = prog_tbl[t][8*(prog_len[t]-1-i) +: 8];
                else
                    image[i] = 8'(i) ^ 8'hA5;
            end
            @(negedge clock);
            rst        = 1'b1;
            test_id    = t;
            exp_count  = exp_n[t];
            exp_vec    = exp_tbl[t];
            begin_test = 1'b1;
            @(negedge clock);
            begin_test = 1'b0;
            repeat (2) @(negedge clock);
            rst = 1'b0;
            while (!halted)
                @(negedge clock);
            repeat (6) @(negedge clock);    // Nothing may follow HALT
            end_test = 1'b1;
            @(negedge clock);
            end_test = 1'b0;
        end

        @(negedge clock);
        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule
